/* hdl/alu.sv */
`timescale 1ns/100ps

module alu (
  alu_if.alu aluif
);
  import cpu_types_pkg::*;

  // shift amounts come in already cut to five bits
  always_comb
  begin
    case (aluif.aluOp)
      ADD:  aluif.port_out = aluif.port_a + aluif.port_b;
      SUB:  aluif.port_out = aluif.port_a - aluif.port_b;
      SLL:  aluif.port_out = aluif.port_a << aluif.port_b;
      SRL:  aluif.port_out = aluif.port_a >> aluif.port_b;
      SRA:  aluif.port_out = word_t'($signed(aluif.port_a) >>> aluif.port_b);
      AND:  aluif.port_out = aluif.port_a & aluif.port_b;
      OR:   aluif.port_out = aluif.port_a | aluif.port_b;
      XOR:  aluif.port_out = aluif.port_a ^ aluif.port_b;
      SLT:
      begin
        aluif.port_out = {31'b0, $signed(aluif.port_a) < $signed(aluif.port_b)};
      end
      SLTU:
      begin
        aluif.port_out = {31'b0, aluif.port_a < aluif.port_b};
      end
      default: aluif.port_out = '0;
    endcase
  end

  // beq and bne look at this after a subtract
  assign aluif.zero = (aluif.port_out == '0);

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
  control_unit_if.cu cuif
);
  import cpu_types_pkg::*;

  opcode_t   op;
  logic [2:0] f3;

  // shared by R and I forms, alt picks SUB or SRA
  function automatic aluop_t alu_decode(input logic [2:0] fn, input logic alt);
    aluop_t res;
    case (fn)
      3'b000: res = alt ? SUB : ADD;
      3'b001: res = SLL;
      3'b010: res = SLT;
      3'b011: res = SLTU;
      3'b100: res = XOR;
      3'b101: res = alt ? SRA : SRL;
      3'b110: res = OR;
      default: res = AND;
    endcase
    return res;
  endfunction

  assign op = opcode_t'(cuif.instr[6:0]);
  assign f3 = cuif.instr[14:12];

  // register fields straight from the encoding
  assign cuif.rs1 = cuif.instr[19:15];
  assign cuif.rs2 = cuif.instr[24:20];
  assign cuif.rd  = cuif.instr[11:7];

  // store immediate is split around rd
  assign cuif.imm = (op == STORE) ? {cuif.instr[31:25], cuif.instr[11:7]}
                                  : cuif.instr[31:20];

  always_comb
  begin
    cuif.aluOp  = ADD;
    cuif.aluSrc = 1'b0;
    cuif.shift  = 1'b0;
    cuif.rdSel  = RD_ALU;
    cuif.regWr  = 1'b0;
    cuif.pcSrc  = PC_SEQ;
    cuif.jpSel  = 1'b0;
    cuif.dREN   = 1'b0;
    cuif.dWEN   = 1'b0;
    cuif.iREN   = 1'b1;
    cuif.halt   = 1'b0;

    case (op)
      RTYPE:
      begin
        cuif.aluOp = alu_decode(f3, cuif.instr[30]);
        cuif.shift = (f3 == 3'b001) || (f3 == 3'b101);
        cuif.regWr = 1'b1;
      end
      ITYPE:
      begin
        // addi has no subtract form
        cuif.aluOp  = alu_decode(f3, cuif.instr[30] && (f3 == 3'b101));
        cuif.aluSrc = 1'b1;
        cuif.shift  = (f3 == 3'b001) || (f3 == 3'b101);
        cuif.regWr  = 1'b1;
      end
      LOAD:
      begin
        cuif.aluSrc = 1'b1;
        cuif.rdSel  = RD_MEM;
        cuif.regWr  = 1'b1;
        cuif.dREN   = 1'b1;
      end
      STORE:
      begin
        cuif.aluSrc = 1'b1;
        cuif.dWEN   = 1'b1;
      end
      BRANCH:
      begin
        // compare through the alu, flags resolved in the datapath
        case (f3)
          BEQ, BNE:   cuif.aluOp = SUB;
          BLT, BGE:   cuif.aluOp = SLT;
          default:    cuif.aluOp = SLTU;
        endcase
        cuif.pcSrc = PC_REL;
      end
      JAL:
      begin
        cuif.rdSel = RD_NPC;
        cuif.regWr = 1'b1;
        cuif.pcSrc = PC_REL;
        cuif.jpSel = 1'b1;
      end
      JALR:
      begin
        cuif.aluSrc = 1'b1;
        cuif.rdSel  = RD_NPC;
        cuif.regWr  = 1'b1;
        cuif.pcSrc  = PC_ALU;
      end
      LUI:
      begin
        cuif.rdSel = RD_LUI;
        cuif.regWr = 1'b1;
      end
      AUIPC:
      begin
        cuif.rdSel = RD_AUIPC;
        cuif.regWr = 1'b1;
      end
      HALT:
      begin
        cuif.iREN = 1'b0;
        cuif.halt = 1'b1;
      end
      default:
      begin
        cuif.iREN = 1'b1;
      end
    endcase
  end

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                 CLK,
  input  logic                 nRST,
  output logic                 imem_ren,
  output cpu_types_pkg::word_t imem_addr,
  input  cpu_types_pkg::word_t imem_load,
  input  logic                 ihit,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output cpu_types_pkg::word_t dmem_addr,
  output cpu_types_pkg::word_t dmem_store,
  input  cpu_types_pkg::word_t dmem_load,
  input  logic                 dhit,
  output logic                 halt
);

  datapath_cache_if dcif();

  datapath #(
    .PC_INIT(PC_INIT)
  ) u_datapath (
    .CLK (CLK),
    .nRST(nRST),
    .dpif(dcif)
  );

  // memory responses in
  assign dcif.imemload = imem_load;
  assign dcif.ihit     = ihit;
  assign dcif.dmemload = dmem_load;
  assign dcif.dhit     = dhit;

  // requests out
  assign imem_ren   = dcif.imemREN;
  assign imem_addr  = dcif.imemaddr;
  assign dmem_ren   = dcif.dmemREN;
  assign dmem_wen   = dcif.dmemWEN;
  assign dmem_addr  = dcif.dmemaddr;
  assign dmem_store = dcif.dmemstore;
  assign halt       = dcif.halt;

endmodule

/* hdl/cpu_ifs.sv */
`timescale 1ns/100ps

// core to memory side
interface datapath_cache_if;
  import cpu_types_pkg::*;

  logic  imemREN, dmemREN, dmemWEN, halt;
  logic  ihit, dhit;
  word_t imemaddr, imemload;
  word_t dmemaddr, dmemstore, dmemload;

  modport dp (
    input  imemload, ihit, dmemload, dhit,
    output imemREN, imemaddr, dmemREN, dmemWEN, dmemaddr, dmemstore, halt
  );
endinterface

interface control_unit_if;
  import cpu_types_pkg::*;

  word_t       instr;
  regbits_t    rs1, rs2, rd;
  logic [11:0] imm;
  aluop_t      aluOp;
  rdsel_t      rdSel;
  pcsrc_t      pcSrc;
  logic        aluSrc, shift, regWr, jpSel, dREN, dWEN, iREN, halt;

  modport cu (
    input  instr,
    output rs1, rs2, rd, imm, aluOp, aluSrc, shift, rdSel, regWr,
           pcSrc, jpSel, dREN, dWEN, iREN, halt
  );
endinterface

interface alu_if;
  import cpu_types_pkg::*;

  aluop_t aluOp;
  word_t  port_a, port_b, port_out;
  logic   zero;

  modport alu (
    input  aluOp, port_a, port_b,
    output port_out, zero
  );
endinterface

interface register_file_if;
  import cpu_types_pkg::*;

  logic     wen;
  regbits_t wsel, rsel1, rsel2;
  word_t    wdat, rdat1, rdat2;

  modport rf (
    input  wen, wsel, wdat, rsel1, rsel2,
    output rdat1, rdat2
  );
endinterface

interface program_counter_if;
  import cpu_types_pkg::*;

  logic  en;
  word_t new_pc, curr_pc, npc;

  modport pc (
    input  en, new_pc,
    output curr_pc, npc
  );
endinterface

interface request_unit_if;
  logic ihit, dhit, dREN, dWEN;
  logic dmemREN, dmemWEN, pcen;

  modport ru (
    input  ihit, dhit, dREN, dWEN,
    output dmemREN, dmemWEN, pcen
  );
endinterface

/* hdl/cpu_types_pkg.sv */
package cpu_types_pkg;

  // basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // major opcodes, HALT is the all-ones encoding
  typedef enum logic [6:0] {
    RTYPE  = 7'b0110011,
    ITYPE  = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    HALT   = 7'b1111111
  } opcode_t;

  // branch conditions in funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } funct3_b_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SRL, SRA, AND, OR, XOR, SLT, SLTU
  } aluop_t;

  // writeback source
  typedef enum logic [2:0] {
    RD_ALU, RD_MEM, RD_NPC, RD_LUI, RD_AUIPC
  } rdsel_t;

  // next pc source
  typedef enum logic [1:0] {
    PC_SEQ, PC_REL, PC_ALU
  } pcsrc_t;

endpackage

/* hdl/datapath.sv */
`timescale 1ns/100ps

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input logic CLK,
  input logic nRST,
  datapath_cache_if.dp dpif
);
  import cpu_types_pkg::*;

  control_unit_if    cuif();
  alu_if             aluif();
  register_file_if   rfif();
  program_counter_if pcif();
  request_unit_if    ruif();

  control_unit u_control_unit (
    .cuif(cuif)
  );

  alu u_alu (
    .aluif(aluif)
  );

  register_file u_register_file (
    .CLK (CLK),
    .nRST(nRST),
    .rfif(rfif)
  );

  program_counter #(
    .PC_INIT(PC_INIT)
  ) u_program_counter (
    .CLK (CLK),
    .nRST(nRST),
    .pcif(pcif)
  );

  request_unit u_request_unit (
    .CLK (CLK),
    .nRST(nRST),
    .ruif(ruif)
  );

  word_t     instr;
  word_t     i_imm, b_imm, j_imm, u_imm;
  funct3_b_t func3;
  logic      branch;

  assign instr     = dpif.imemload;
  assign cuif.instr = instr;
  assign func3     = funct3_b_t'(instr[14:12]);

  // immediates, i and s share the decoder's 12-bit field
  assign i_imm = {{20{cuif.imm[11]}}, cuif.imm};
  assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};

  // register file, writes only when the instruction retires
  assign rfif.rsel1 = cuif.rs1;
  assign rfif.rsel2 = cuif.rs2;
  assign rfif.wsel  = cuif.rd;
  assign rfif.wen   = cuif.regWr && ruif.pcen;

  always_comb
  begin
    case (cuif.rdSel)
      RD_MEM:   rfif.wdat = dpif.dmemload;
      RD_NPC:   rfif.wdat = pcif.npc;
      RD_LUI:   rfif.wdat = u_imm;
      RD_AUIPC: rfif.wdat = pcif.curr_pc + u_imm;
      default:  rfif.wdat = aluif.port_out;
    endcase
  end

  // alu operands
  assign aluif.aluOp  = cuif.aluOp;
  assign aluif.port_a = rfif.rdat1;

  always_comb
  begin
    if (cuif.aluSrc)
    begin
      aluif.port_b = cuif.shift ? {27'b0, i_imm[4:0]} : i_imm;
    end
    else
    begin
      aluif.port_b = cuif.shift ? {27'b0, rfif.rdat2[4:0]} : rfif.rdat2;
    end
  end

  // branch condition from the compare result
  always_comb
  begin
    case (func3)
      BEQ:        branch = aluif.zero;
      BNE:        branch = !aluif.zero;
      BLT, BLTU:  branch = aluif.port_out[0];
      BGE, BGEU:  branch = !aluif.port_out[0];
      default:    branch = 1'b0;
    endcase
  end

  // next pc
  always_comb
  begin
    case (cuif.pcSrc)
      PC_REL:
      begin
        if (cuif.jpSel)
        begin
          pcif.new_pc = pcif.curr_pc + j_imm;
        end
        else
        begin
          pcif.new_pc = branch ? (pcif.curr_pc + b_imm) : pcif.npc;
        end
      end
      PC_ALU:  pcif.new_pc = {aluif.port_out[31:1], 1'b0};
      default: pcif.new_pc = pcif.npc;
    endcase
  end

  // pc stays on the halt instruction
  assign pcif.en = ruif.pcen && !cuif.halt;

  // hits are ignored once halted
  assign ruif.ihit = dpif.ihit && !dpif.halt;
  assign ruif.dhit = dpif.dhit;
  assign ruif.dREN = cuif.dREN;
  assign ruif.dWEN = cuif.dWEN;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      dpif.halt <= 1'b0;
    end
    else
    begin
      dpif.halt <= dpif.halt || (cuif.halt && ruif.ihit);
    end
  end

  assign dpif.imemREN   = cuif.iREN && !dpif.halt;
  assign dpif.imemaddr  = pcif.curr_pc;
  assign dpif.dmemREN   = ruif.dmemREN;
  assign dpif.dmemWEN   = ruif.dmemWEN;
  assign dpif.dmemaddr  = aluif.port_out;
  assign dpif.dmemstore = rfif.rdat2;

endmodule

/* hdl/program_counter.sv */
`timescale 1ns/100ps

module program_counter #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input logic CLK,
  input logic nRST,
  program_counter_if.pc pcif
);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pcif.curr_pc <= PC_INIT;
    end
    else if (pcif.en)
    begin
      pcif.curr_pc <= pcif.new_pc;
    end
  end

  // sequential address, also the link value
  assign pcif.npc = pcif.curr_pc + 32'd4;

endmodule

/* hdl/register_file.sv */
`timescale 1ns/100ps

module register_file (
  input logic CLK,
  input logic nRST,
  register_file_if.rf rfif
);
  import cpu_types_pkg::*;

  word_t regs [32];

  // x0 is cleared here and never written afterwards
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (rfif.wen && (rfif.wsel != '0))
    begin
      regs[rfif.wsel] <= rfif.wdat;
    end
  end

  assign rfif.rdat1 = regs[rfif.rsel1];
  assign rfif.rdat2 = regs[rfif.rsel2];

endmodule

/* hdl/request_unit.sv */
`timescale 1ns/100ps

module request_unit (
  input logic CLK,
  input logic nRST,
  request_unit_if.ru ruif
);

  typedef enum logic {
    IDLE,
    DATA_WAIT
  } state_t;

  state_t state, next_state;
  logic   ren_q, wen_q;
  logic   next_ren, next_wen;
  logic   data_req;

  assign data_req = ruif.dREN || ruif.dWEN;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state <= IDLE;
      ren_q <= 1'b0;
      wen_q <= 1'b0;
    end
    else
    begin
      state <= next_state;
      ren_q <= next_ren;
      wen_q <= next_wen;
    end
  end

  always_comb
  begin
    next_state = state;
    next_ren   = ren_q;
    next_wen   = wen_q;
    case (state)
      IDLE:
      begin
        // a zero-wait dhit finishes in the fetch cycle itself
        if (ruif.ihit && data_req && !ruif.dhit)
        begin
          next_state = DATA_WAIT;
          next_ren   = ruif.dREN;
          next_wen   = ruif.dWEN;
        end
      end
      DATA_WAIT:
      begin
        if (ruif.dhit)
        begin
          next_state = IDLE;
          next_ren   = 1'b0;
          next_wen   = 1'b0;
        end
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  // strobe goes up in the fetch cycle, then the held copy keeps it
  assign ruif.dmemREN = ren_q || ((state == IDLE) && ruif.ihit && ruif.dREN);
  assign ruif.dmemWEN = wen_q || ((state == IDLE) && ruif.ihit && ruif.dWEN);

  assign ruif.pcen = (ruif.ihit && !data_req) || ruif.dhit;

endmodule

/* project.f */
+incdir+tests
hdl/cpu_types_pkg.sv
hdl/cpu_ifs.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/register_file.sv
hdl/program_counter.sv
hdl/request_unit.sv
hdl/datapath.sv
hdl/cpu_core.sv
tests/tb_cpu_core.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run the testbench into sim.log, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cpu_core -f project.f -o sim_cpu \
  && ./obj_dir/sim_cpu > sim.log 2>&1

grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* tests/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int    PROG_LEN = 64;
localparam int    DWORDS   = 32;
localparam word_t DBASE    = 32'h0000_2000;

word_t imem [PROG_LEN];
word_t m_regs [32];
word_t m_dmem [DWORDS];
word_t m_pc;
// address and store data of the last load or store
word_t m_addr;
word_t m_wdata;
int    m_count;

function automatic word_t rtype_word(input logic alt, input regbits_t rs2,
                                     input regbits_t rs1, input logic [2:0] f3,
                                     input regbits_t rd);
  return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, RTYPE};
endfunction

function automatic word_t itype_word(input logic [11:0] imm, input regbits_t rs1,
                                     input logic [2:0] f3, input regbits_t rd,
                                     input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t store_word(input logic [11:0] imm, input regbits_t rs2,
                                     input regbits_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
endfunction

function automatic word_t branch_word(input logic [12:0] off, input regbits_t rs2,
                                      input regbits_t rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
endfunction

function automatic word_t jal_word(input logic [20:0] off, input regbits_t rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
endfunction

function automatic word_t upper_word(input logic [19:0] imm, input regbits_t rd,
                                     input logic [6:0] op);
  return {imm, rd, op};
endfunction

// anything outside the program reads as halt
function automatic word_t fetch_word(input word_t addr);
  word_t off;
  off = addr - PC_INIT;
  if ((off[1:0] != 2'b00) || (off >= 32'(PROG_LEN * 4)))
  begin
    return {25'b0, HALT};
  end
  return imem[off[7:2]];
endfunction

function automatic int didx(input word_t addr);
  word_t off;
  off = addr - DBASE;
  return int'(off[6:2]);
endfunction

function automatic word_t fill_word(input word_t addr);
  return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
  word_t res;
  case (f3)
    3'd0: res = alt ? (a - b) : (a + b);
    3'd1: res = a << b[4:0];
    3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: res = (a < b) ? 32'd1 : 32'd0;
    3'd4: res = a ^ b;
    3'd5:
    begin
      if (alt)
        res = $signed(a) >>> b[4:0];
      else
        res = a >> b[4:0];
    end
    3'd6: res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

// executes one instruction straight from its encoding
task automatic model_step(input word_t ins);
  word_t      a, b, res, nxt;
  word_t      imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [2:0] f3;
  logic       wr, take;
  a     = m_regs[ins[19:15]];
  b     = m_regs[ins[24:20]];
  f3    = ins[14:12];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  imm_u = {ins[31:12], 12'b0};
  res   = '0;
  wr    = 1'b1;
  take  = 1'b0;
  nxt   = m_pc + 32'd4;
  case (ins[6:0])
    RTYPE: res = alu_ref(f3, ins[30], a, b);
    ITYPE: res = alu_ref(f3, ins[30] && (f3 == 3'd5), a, imm_i);
    LOAD:
    begin
      m_addr = a + imm_i;
      res    = m_dmem[didx(m_addr)];
    end
    STORE:
    begin
      wr      = 1'b0;
      m_addr  = a + imm_s;
      m_wdata = b;
      m_dmem[didx(m_addr)] = b;
    end
    BRANCH:
    begin
      wr = 1'b0;
      case (f3)
        3'b000: take = (a == b);
        3'b001: take = (a != b);
        3'b100: take = $signed(a) < $signed(b);
        3'b101: take = $signed(a) >= $signed(b);
        3'b110: take = a < b;
        default: take = a >= b;
      endcase
      if (take)
        nxt = m_pc + imm_b;
    end
    JAL:
    begin
      res = m_pc + 32'd4;
      nxt = m_pc + imm_j;
    end
    JALR:
    begin
      res = m_pc + 32'd4;
      nxt = (a + imm_i) & ~32'd1;
    end
    LUI:   res = imm_u;
    AUIPC: res = m_pc + imm_u;
    default: wr = 1'b0;
  endcase
  if (wr && (ins[11:7] != 5'd0))
    m_regs[ins[11:7]] = res;
  m_pc = nxt;
  m_count++;
endtask

// x1 holds the data base and x2 the jalr target
// jumps only go forward
task automatic gen_program();
  int          i;
  int          k;
  logic [2:0]  kind, f3, off;
  logic        alt;
  regbits_t    rd, rs1, rs2;
  logic [11:0] imm;
  logic [20:0] jump;
  word_t       target, hi;
  logic        is_target [PROG_LEN];
  for (int j = 0; j < PROG_LEN; j++)
    is_target[j] = 1'b0;
  imem[0] = upper_word(DBASE[31:12], 5'd1, LUI);
  i = 1;
  while (i < PROG_LEN - 1)
  begin
    kind = 3'(lfsr_bits(3));
    rd   = 5'(lfsr_bits(5));
    rs1  = 5'(lfsr_bits(5));
    rs2  = 5'(lfsr_bits(5));
    f3   = 3'(lfsr_bits(3));
    imm  = 12'(lfsr_bits(12));
    alt  = 1'(lfsr_bits(1));
    off  = 3'(lfsr_bits(3));
    if (rd == 5'd1)
      rd = 5'd0;
    k = 1 + int'(off);
    if (i + k > PROG_LEN - 1)
      k = PROG_LEN - 1 - i;
    jump = 21'(k * 4);
    case (kind)
      3'd0: imem[i] = rtype_word(alt && ((f3 == 3'd0) || (f3 == 3'd5)), rs2, rs1, f3, rd);
      3'd1:
      begin
        if ((f3 == 3'd1) || (f3 == 3'd5))
          imm = {1'b0, alt && (f3 == 3'd5), 5'b0, imm[4:0]};
        imem[i] = itype_word(imm, rs1, f3, rd, ITYPE);
      end
      3'd2: imem[i] = itype_word({5'b0, imm[4:0], 2'b0}, 5'd1, 3'b010, rd, LOAD);
      3'd3: imem[i] = store_word({5'b0, imm[4:0], 2'b0}, rs2, 5'd1);
      3'd4:
      begin
        // funct3 2 and 3 are not branches
        if ((f3 == 3'd2) || (f3 == 3'd3))
          f3 = {2'b00, f3[0]};
        imem[i] = branch_word(jump[12:0], rs2, rs1, f3);
        is_target[i + k] = 1'b1;
      end
      3'd5:
      begin
        imem[i] = jal_word(jump, rd);
        is_target[i + k] = 1'b1;
      end
      3'd6:
      begin
        // a jump may enter the lui, addi, jalr group only at its lui
        if ((i <= PROG_LEN - 4) && !is_target[i + 1] && !is_target[i + 2])
        begin
          k = i + 3 + int'(off);
          if (k > PROG_LEN - 1)
            k = PROG_LEN - 1;
          is_target[k] = 1'b1;
          target = PC_INIT + 32'(k * 4);
          hi     = target + 32'h800;
          imem[i]     = upper_word(hi[31:12], 5'd2, LUI);
          imem[i + 1] = itype_word(target[11:0], 5'd2, 3'b000, 5'd2, ITYPE);
          imem[i + 2] = itype_word(12'd0, 5'd2, 3'b000, rd, JALR);
          i = i + 2;
        end
        else
          imem[i] = itype_word(imm, rs1, 3'b000, rd, ITYPE);
      end
      default: imem[i] = upper_word({imm, imm[7:0]}, rd, alt ? AUIPC : LUI);
    endcase
    i++;
  end
  imem[PROG_LEN - 1] = {25'b0, HALT};
endtask

`endif

/* tests/tb_cpu_core.sv */
`timescale 1ns/100ps

module tb_cpu_core;
  import cpu_types_pkg::*;

  localparam word_t PC_INIT = 32'h0000_0100;

  logic  CLK, nRST;
  logic  imem_ren, ihit, dmem_ren, dmem_wen, dhit, halt;
  word_t imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;

  word_t lfsr_state = 32'h93ac;

  // galois lfsr stepped once per bit
  function automatic word_t lfsr_bits(input int n);
    word_t v;
    logic  lsb;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      v = {v[30:0], lsb};
    end
    return v;
  endfunction

  `include "cpu_model.svh"

  // at most 8 cycles per instruction plus reset and halt tail
  localparam int WATCHDOG_NS = PROG_LEN * 2 * 4 * 10 + 500;

  word_t bus_dmem [DWORDS];
  logic  fetch_valid, dbusy, halt_seen, d_ren_q, d_wen_q;
  word_t fetch_addr, d_addr_q, d_store_q;
  int    iwait, dwait, dut_count, errors, checks;

  cpu_core #(
    .PC_INIT(PC_INIT)
  ) u_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .imem_ren  (imem_ren),
    .imem_addr (imem_addr),
    .imem_load (imem_load),
    .ihit      (ihit),
    .dmem_ren  (dmem_ren),
    .dmem_wen  (dmem_wen),
    .dmem_addr (dmem_addr),
    .dmem_store(dmem_store),
    .dmem_load (dmem_load),
    .dhit      (dhit),
    .halt      (halt)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task expect_no_data();
    check_word("dmem_ren", {31'b0, dmem_ren}, 32'd0);
    check_word("dmem_wen", {31'b0, dmem_wen}, 32'd0);
  endtask

  // memory models with 0 to 3 wait states on each hit
  task drive_memories();
    if (!fetch_valid || (imem_addr !== fetch_addr))
    begin
      fetch_valid = 1'b1;
      fetch_addr  = imem_addr;
      iwait       = int'(lfsr_bits(2));
      dut_count++;
    end
    else if (iwait > 0)
      iwait--;
    imem_load = fetch_word(fetch_addr);
    ihit      = (iwait == 0);
    dhit      = 1'b0;
    if (dbusy)
    begin
      if (dwait == 0)
      begin
        dhit      = 1'b1;
        dmem_load = bus_dmem[didx(d_addr_q)];
      end
      else
        dwait--;
    end
  endtask

  // sampled mid-cycle when all outputs have settled
  task sample_cycle();
    word_t ins;
    ins = fetch_word(m_pc);
    if (!halt_seen)
      check_word("halt", {31'b0, halt}, 32'd0);
    // fetch stays enabled up to the halt instruction
    if (ihit && (ins[6:0] != HALT))
      check_word("imem_ren", {31'b0, imem_ren}, 32'd1);
    if (dbusy)
    begin
      // request held and fetch frozen until dhit
      check_word("dmem_addr", dmem_addr, d_addr_q);
      check_word("dmem_ren", {31'b0, dmem_ren}, {31'b0, d_ren_q});
      check_word("dmem_wen", {31'b0, dmem_wen}, {31'b0, d_wen_q});
      check_word("imem_addr", imem_addr, fetch_addr);
      if (d_wen_q)
        check_word("dmem_store", dmem_store, d_store_q);
      if (dhit)
      begin
        model_step(ins);
        check_word("dmem_addr", dmem_addr, m_addr);
        if (d_wen_q)
        begin
          check_word("dmem_store", dmem_store, m_wdata);
          bus_dmem[didx(dmem_addr)] = dmem_store;
        end
        dbusy = 1'b0;
      end
    end
    else if (ihit)
    begin
      check_word("imem_addr", imem_addr, m_pc);
      if (ins[6:0] == HALT)
      begin
        halt_seen = 1'b1;
        m_count++;
        expect_no_data();
      end
      else if ((ins[6:0] == LOAD) || (ins[6:0] == STORE))
      begin
        dbusy     = 1'b1;
        dwait     = int'(lfsr_bits(2));
        d_addr_q  = dmem_addr;
        d_store_q = dmem_store;
        d_ren_q   = (ins[6:0] == LOAD);
        d_wen_q   = (ins[6:0] == STORE);
        check_word("dmem_ren", {31'b0, dmem_ren}, {31'b0, d_ren_q});
        check_word("dmem_wen", {31'b0, dmem_wen}, {31'b0, d_wen_q});
      end
      else
      begin
        expect_no_data();
        model_step(ins);
      end
    end
    else
      expect_no_data();
  endtask

  initial
  begin
    nRST      = 1'b0;
    ihit      = 1'b0;
    dhit      = 1'b0;
    imem_load = '0;
    dmem_load = '0;
    errors    = 0;
    checks    = 0;
    dut_count = 0;
    m_count   = 0;
    iwait     = 0;
    dwait     = 0;
    dbusy     = 1'b0;
    halt_seen = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    m_pc      = PC_INIT;
    for (int i = 0; i < 32; i++)
      m_regs[i] = '0;
    for (int i = 0; i < DWORDS; i++)
    begin
      m_dmem[i]   = fill_word(DBASE + 32'(i * 4));
      bus_dmem[i] = m_dmem[i];
    end
    gen_program();

    @(posedge CLK);
    @(negedge CLK);
    check_word("imem_addr", imem_addr, PC_INIT);
    check_word("halt", {31'b0, halt}, 32'd0);
    expect_no_data();
    @(posedge CLK);
    #1;
    nRST = 1'b1;

    while (!halt_seen)
    begin
      drive_memories();
      @(negedge CLK);
      sample_cycle();
      @(posedge CLK);
      #1;
    end

    // halt stays up and the pc stays on the halt instruction
    repeat (4)
    begin
      @(negedge CLK);
      check_word("halt", {31'b0, halt}, 32'd1);
      check_word("imem_addr", imem_addr, m_pc);
      check_word("imem_ren", {31'b0, imem_ren}, 32'd0);
      expect_no_data();
    end
    check_word("instr_count", 32'(dut_count), 32'(m_count));

    $display("checks: %0d  errors: %0d  instructions: %0d", checks, errors, m_count);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the core did not halt within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule
